/* Makefile */
OUT := obj_dir
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f \
		--top-module pipeCoreTb -Mdir $(OUT) -o simv

run: build
	./$(OUT)/simv | tee $(LOG)
	grep -q "Everything OK" $(LOG)

lint:
	verilator --lint-only --timing -Wall --timescale 1ns/1ps -f flist.f --top-module pipeCoreTb

clean:
	rm -rf $(OUT) $(LOG)

/* design/alu.sv */
`timescale 1ns/1ps

module alu
    import rvPkg::*;
(
    input  logic [Xlen-1:0] a,
    input  logic [Xlen-1:0] b,
    input  aluOpT           aluOp,
    output logic [Xlen-1:0] result,
    output logic            zero
);

    localparam int ShamtW = $clog2(Xlen);

    logic [ShamtW-1:0] shamt;

    assign shamt = b[ShamtW-1:0];

    always_comb begin
        case (aluOp)
            AluAdd:  result = a + b;
            AluSub:  result = a - b;
            AluAnd:  result = a & b;
            AluOr:   result = a | b;
            AluXor:  result = a ^ b;
            AluSll:  result = a << shamt;
            AluSrl:  result = a >> shamt;
            AluSra:  result = $signed(a) >>> shamt;
            AluSlt:  result = {{(Xlen-1){1'b0}}, $signed(a) < $signed(b)};
            AluSltu: result = {{(Xlen-1){1'b0}}, a < b};
            default: result = '0;
        endcase
    end

    // Branch compare relies on this after a subtract
    assign zero = (result == '0);

    always_comb begin
        // EX register holds no decoded op before its first load
        if (!$isunknown(aluOp)) begin
            assert (aluOp inside {AluAdd, AluSub, AluAnd, AluOr, AluXor,
                                  AluSll, AluSrl, AluSra, AluSlt, AluSltu})
                else $error("alu: undefined operation %0d", aluOp);
        end
    end

endmodule

/* design/exStage.sv */
`timescale 1ns/1ps

module exStage
    import rvPkg::*;
(
    input  logic [exCtrlW-1:0]  exCtrl,
    input  logic [Xlen-1:0]     pc,
    input  logic [Xlen-1:0]     imm,
    input  logic [RegAddrW-1:0] rs1,
    input  logic [RegAddrW-1:0] rs2,
    input  logic [Xlen-1:0]     rd1,
    input  logic [Xlen-1:0]     rd2,
    input  aluOpT               aluOp,
    input  logic [RegAddrW-1:0] exMemRd,
    input  logic                exMemRegWrite,
    input  logic [Xlen-1:0]     exMemResult,
    input  logic [RegAddrW-1:0] memWbRd,
    input  logic                memWbRegWrite,
    input  logic [Xlen-1:0]     wbData,
    output logic [Xlen-1:0]     result,
    output logic [Xlen-1:0]     targetPc,
    output logic                taken,
    output logic [exCtrlW-1:0]  outCtrl
);

    logic [Xlen-1:0] opA;
    logic [Xlen-1:0] opB;
    logic [Xlen-1:0] aluB;
    logic            zero;

    forwardUnit fwdUnit (
        .rs1           (rs1),
        .rs2           (rs2),
        .exMemRd       (exMemRd),
        .exMemRegWrite (exMemRegWrite),
        .memWbRd       (memWbRd),
        .memWbRegWrite (memWbRegWrite),
        .exMemResult   (exMemResult),
        .wbData        (wbData),
        .rd1           (rd1),
        .rd2           (rd2),
        .opA           (opA),
        .opB           (opB)
    );

    // Second ALU operand
    assign aluB = exCtrl[CtrlAluSrc] ? imm : opB;

    alu aluUnit (
        .a      (opA),
        .b      (aluB),
        .aluOp  (aluOp),
        .result (result),
        .zero   (zero)
    );

    // Immediate is already a byte offset
    assign targetPc = pc + imm;
    assign taken    = exCtrl[CtrlValid] && exCtrl[CtrlBranch] &&
                      (exCtrl[CtrlBne] ? !zero : zero);

    // Branches and bubbles leave nothing to retire
    always_comb begin
        outCtrl = exCtrl;
        if (!exCtrl[CtrlValid] || exCtrl[CtrlBranch]) begin
            outCtrl[CtrlRegWrite] = 1'b0;
            outCtrl[CtrlValid]    = 1'b0;
        end
    end

endmodule

/* design/forwardUnit.sv */
`timescale 1ns/1ps

module forwardUnit
    import rvPkg::*;
(
    input  logic [RegAddrW-1:0] rs1,
    input  logic [RegAddrW-1:0] rs2,
    input  logic [RegAddrW-1:0] exMemRd,
    input  logic                exMemRegWrite,
    input  logic [RegAddrW-1:0] memWbRd,
    input  logic                memWbRegWrite,
    input  logic [Xlen-1:0]     exMemResult,
    input  logic [Xlen-1:0]     wbData,
    input  logic [Xlen-1:0]     rd1,
    input  logic [Xlen-1:0]     rd2,
    output logic [Xlen-1:0]     opA,
    output logic [Xlen-1:0]     opB
);

    fwdSelT selA;
    fwdSelT selB;

    // MEM stage holds the newer value, so it wins over WB
    function automatic fwdSelT pickSrc(input logic [RegAddrW-1:0] rs,
                                       input logic [RegAddrW-1:0] memRd,
                                       input logic                memWe,
                                       input logic [RegAddrW-1:0] wbRd,
                                       input logic                wbWe);
        fwdSelT sel;
        sel = fromRegFile;
        if (wbWe && wbRd != '0 && wbRd == rs) sel = fromMemWb;
        if (memWe && memRd != '0 && memRd == rs) sel = fromExMem;
        return sel;
    endfunction

    assign selA = pickSrc(rs1, exMemRd, exMemRegWrite, memWbRd, memWbRegWrite);
    assign selB = pickSrc(rs2, exMemRd, exMemRegWrite, memWbRd, memWbRegWrite);

    always_comb begin
        case (selA)
            fromExMem: opA = exMemResult;
            fromMemWb: opA = wbData;
            default:   opA = rd1;
        endcase
        case (selB)
            fromExMem: opB = exMemResult;
            fromMemWb: opB = wbData;
            default:   opB = rd2;
        endcase
    end

    always_comb begin
        if (exMemRd == '0) begin
            assert (selA != fromExMem && selB != fromExMem)
                else $error("forwardUnit: x0 forwarded from the MEM stage");
        end
    end

endmodule

/* design/instDecode.sv */
`timescale 1ns/1ps

module instDecode
    import rvPkg::*;
(
    input  logic [Xlen-1:0]     word,
    output logic [RegAddrW-1:0] rs1,
    output logic [RegAddrW-1:0] rs2,
    output logic [RegAddrW-1:0] rd,
    output logic [Xlen-1:0]     imm,
    output aluOpT               aluOp,
    output logic [exCtrlW-1:0]  exCtrl
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [Xlen-1:0] immI;
    logic [Xlen-1:0] immB;
    logic            altForm;

    // Shared funct3 mapping for register and immediate forms
    function automatic aluOpT mapOp(input logic [2:0] f3, input logic subAllowed,
                                    input logic alt);
        aluOpT op;
        case (f3)
            F3AddSub: op = (subAllowed && alt) ? AluSub : AluAdd;
            F3Sll:    op = AluSll;
            F3Slt:    op = AluSlt;
            F3Sltu:   op = AluSltu;
            F3Xor:    op = AluXor;
            F3SrlSra: op = alt ? AluSra : AluSrl;
            F3Or:     op = AluOr;
            F3And:    op = AluAnd;
            default:  op = AluAdd;
        endcase
        return op;
    endfunction

    assign opcode  = word[6:0];
    assign rd      = word[11:7];
    assign funct3  = word[14:12];
    assign rs1     = word[19:15];
    assign rs2     = word[24:20];
    assign funct7  = word[31:25];
    assign altForm = (funct7 == F7Alt);

    assign immI = {{20{word[31]}}, word[31:20]};
    // Byte offset, bit 0 always zero
    assign immB = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
    assign imm  = (opcode == OpBranch) ? immB : immI;

    always_comb begin
        aluOp  = AluAdd;
        exCtrl = '0;
        case (opcode)
            OpReg: begin
                aluOp = mapOp(funct3, 1'b1, altForm);
                // Alternate funct7 only exists for SUB and SRA
                if (funct7 == F7Base ||
                    (altForm && (funct3 == F3AddSub || funct3 == F3SrlSra))) begin
                    exCtrl[CtrlRegWrite] = 1'b1;
                    exCtrl[CtrlValid]    = 1'b1;
                end
            end
            OpImm: begin
                aluOp = mapOp(funct3, 1'b0, altForm);
                exCtrl[CtrlAluSrc]   = 1'b1;
                exCtrl[CtrlRegWrite] = 1'b1;
                exCtrl[CtrlValid]    = 1'b1;
                // Shift immediates carry funct7 in the upper bits
                if (funct3 == F3Sll && funct7 != F7Base) begin
                    exCtrl = '0;
                end
                if (funct3 == F3SrlSra && funct7 != F7Base && !altForm) begin
                    exCtrl = '0;
                end
            end
            OpBranch: begin
                // Compare by subtraction, zero flag decides
                aluOp = AluSub;
                if (funct3 == F3Beq || funct3 == F3Bne) begin
                    exCtrl[CtrlBranch] = 1'b1;
                    exCtrl[CtrlBne]    = (funct3 == F3Bne);
                    exCtrl[CtrlValid]  = 1'b1;
                end
            end
            default: begin
                exCtrl = '0;
            end
        endcase
    end

endmodule

/* design/pipeCore.sv */
`timescale 1ns/1ps

module pipeCore
    import rvPkg::*;
(
    input  logic                clk,
    input  logic                arstN,
    input  logic                instValid,
    input  logic [Xlen-1:0]     instWord,
    input  logic [Xlen-1:0]     instPc,
    output logic                wbValid,
    output logic [RegAddrW-1:0] wbRd,
    output logic [Xlen-1:0]     wbData,
    output logic                redirect,
    output logic [Xlen-1:0]     redirectPc
);

    // ID register
    logic            idValid;
    logic [Xlen-1:0] idWord;
    logic [Xlen-1:0] idPc;

    // Decode and register read
    logic [RegAddrW-1:0] decRs1;
    logic [RegAddrW-1:0] decRs2;
    logic [RegAddrW-1:0] decRd;
    logic [Xlen-1:0]     decImm;
    aluOpT               decAluOp;
    logic [exCtrlW-1:0]  decCtrl;
    logic [Xlen-1:0]     rfRd1;
    logic [Xlen-1:0]     rfRd2;

    // EX register
    logic [exCtrlW-1:0]  exCtrlQ;
    logic [Xlen-1:0]     exPc;
    logic [Xlen-1:0]     exImm;
    logic [Xlen-1:0]     exRd1;
    logic [Xlen-1:0]     exRd2;
    logic [RegAddrW-1:0] exRs1;
    logic [RegAddrW-1:0] exRs2;
    logic [RegAddrW-1:0] exRd;
    aluOpT               exAluOp;

    // Execute results
    logic [Xlen-1:0]    exResult;
    logic [Xlen-1:0]    exTarget;
    logic               exTaken;
    logic [exCtrlW-1:0] exOutCtrl;

    // MEM register
    logic                memValid;
    logic                memRegWrite;
    logic [RegAddrW-1:0] memRd;
    logic [Xlen-1:0]     memResult;

    // WB register
    logic                wbStValid;
    logic                wbStRegWrite;
    logic [RegAddrW-1:0] wbStRd;
    logic [Xlen-1:0]     wbStResult;

    logic exMemRegWrite;
    logic memWbRegWrite;

    instDecode decoder (
        .word   (idWord),
        .rs1    (decRs1),
        .rs2    (decRs2),
        .rd     (decRd),
        .imm    (decImm),
        .aluOp  (decAluOp),
        .exCtrl (decCtrl)
    );

    regFile regs (
        .clk   (clk),
        .arstN (arstN),
        .rs1   (decRs1),
        .rs2   (decRs2),
        .we    (memWbRegWrite),
        .wd    (wbRd),
        .wdata (wbData),
        .rd1   (rfRd1),
        .rd2   (rfRd2)
    );

    exStage execute (
        .exCtrl        (exCtrlQ),
        .pc            (exPc),
        .imm           (exImm),
        .rs1           (exRs1),
        .rs2           (exRs2),
        .rd1           (exRd1),
        .rd2           (exRd2),
        .aluOp         (exAluOp),
        .exMemRd       (memRd),
        .exMemRegWrite (exMemRegWrite),
        .exMemResult   (memResult),
        .memWbRd       (wbStRd),
        .memWbRegWrite (memWbRegWrite),
        .wbData        (wbData),
        .result        (exResult),
        .targetPc      (exTarget),
        .taken         (exTaken),
        .outCtrl       (exOutCtrl)
    );

    assign exMemRegWrite = memValid && memRegWrite;
    assign memWbRegWrite = wbStValid && wbStRegWrite;

    assign redirect   = exTaken;
    assign redirectPc = exTarget;

    // Retire port hides x0 writes
    assign wbValid = memWbRegWrite && (wbStRd != '0);
    assign wbRd    = wbStRd;
    assign wbData  = wbStResult;

    // A taken branch kills the offered word and the one in ID
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idValid      <= 1'b0;
            exCtrlQ      <= '0;
            memValid     <= 1'b0;
            memRegWrite  <= 1'b0;
            wbStValid    <= 1'b0;
            wbStRegWrite <= 1'b0;
        end else begin
            idValid      <= instValid && !redirect;
            exCtrlQ      <= (idValid && !redirect) ? decCtrl : '0;
            memValid     <= exOutCtrl[CtrlValid];
            memRegWrite  <= exOutCtrl[CtrlRegWrite];
            wbStValid    <= memValid;
            wbStRegWrite <= memRegWrite;
        end
    end

    // Payload follows the valid bits
    always_ff @(posedge clk) begin
        idWord     <= instWord;
        idPc       <= instPc;
        exPc       <= idPc;
        exImm      <= decImm;
        exRd1      <= rfRd1;
        exRd2      <= rfRd2;
        exRs1      <= decRs1;
        exRs2      <= decRs2;
        exRd       <= decRd;
        exAluOp    <= decAluOp;
        memRd      <= exRd;
        memResult  <= exResult;
        wbStRd     <= memRd;
        wbStResult <= memResult;
    end

    redirectFromValid: assert property (@(posedge clk) disable iff (!arstN)
        redirect |-> exCtrlQ[CtrlValid])
        else $error("pipeCore: redirect raised with an empty EX stage");

endmodule

/* design/regFile.sv */
`timescale 1ns/1ps

module regFile
    import rvPkg::*;
(
    input  logic                clk,
    input  logic                arstN,
    input  logic [RegAddrW-1:0] rs1,
    input  logic [RegAddrW-1:0] rs2,
    input  logic                we,
    input  logic [RegAddrW-1:0] wd,
    input  logic [Xlen-1:0]     wdata,
    output logic [Xlen-1:0]     rd1,
    output logic [Xlen-1:0]     rd2
);

    logic [Xlen-1:0] regs [2**RegAddrW];
    logic            wrLive;

    // x0 is never written
    assign wrLive = we && (wd != '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 2**RegAddrW; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[wd] <= wdata;
        end
    end

    // Write-through so the ID stage sees the value retiring this cycle
    always_comb begin
        rd1 = (wrLive && wd == rs1) ? wdata : regs[rs1];
        rd2 = (wrLive && wd == rs2) ? wdata : regs[rs2];
        if (rs1 == '0) rd1 = '0;
        if (rs2 == '0) rd2 = '0;
    end

    zeroKept: assert property (@(posedge clk) disable iff (!arstN)
        we && wd == '0 |=> regs[0] == '0)
        else $error("regFile: write to x0 changed the stored zero");

endmodule

/* design/rvPkg.sv */
package rvPkg;

    // Datapath sizes fixed by RV32I
    localparam int Xlen     = 32;
    localparam int RegAddrW = 5;

    // Execute control bundle layout
    localparam int exCtrlW      = 5;
    localparam int CtrlRegWrite = 4;
    localparam int CtrlAluSrc   = 3;
    localparam int CtrlBranch   = 2;
    localparam int CtrlBne      = 1;
    localparam int CtrlValid    = 0;

    // Major opcodes of the supported subset
    localparam logic [6:0] OpReg    = 7'b0110011;
    localparam logic [6:0] OpImm    = 7'b0010011;
    localparam logic [6:0] OpBranch = 7'b1100011;

    // funct3 for ALU operations
    localparam logic [2:0] F3AddSub = 3'b000;
    localparam logic [2:0] F3Sll    = 3'b001;
    localparam logic [2:0] F3Slt    = 3'b010;
    localparam logic [2:0] F3Sltu   = 3'b011;
    localparam logic [2:0] F3Xor    = 3'b100;
    localparam logic [2:0] F3SrlSra = 3'b101;
    localparam logic [2:0] F3Or     = 3'b110;
    localparam logic [2:0] F3And    = 3'b111;

    // funct3 for branches
    localparam logic [2:0] F3Beq = 3'b000;
    localparam logic [2:0] F3Bne = 3'b001;

    // funct7, alternate form selects SUB and SRA
    localparam logic [6:0] F7Base = 7'b0000000;
    localparam logic [6:0] F7Alt  = 7'b0100000;

    typedef enum logic [3:0] {
        AluAdd, AluSub, AluAnd, AluOr, AluXor, AluSll, AluSrl, AluSra, AluSlt, AluSltu
    } aluOpT;

    typedef enum logic [1:0] {
        fromRegFile = 2'b00,
        fromMemWb   = 2'b01,
        fromExMem   = 2'b10
    } fwdSelT;

endpackage

/* flist.f */
design/rvPkg.sv
design/instDecode.sv
design/regFile.sv
design/forwardUnit.sv
design/alu.sv
design/exStage.sv
design/pipeCore.sv
verif/pipeCoreTb.sv

/* verif/pipeCoreTb.sv */
`timescale 1ns/1ps

module pipeCoreTb
    import rvPkg::*;
();

    localparam int ClkPeriod   = 8;
    localparam int ResetCycles = 16;
    localparam int Seed        = 66815;
    localparam logic [Xlen-1:0] StartPc = 32'h0000_0100;

    logic                clk;
    logic                arstN;
    logic                instValid;
    logic [Xlen-1:0]     instWord;
    logic [Xlen-1:0]     instPc;
    logic                wbValid;
    logic [RegAddrW-1:0] wbRd;
    logic [Xlen-1:0]     wbData;
    logic                redirect;
    logic [Xlen-1:0]     redirectPc;

    // Reference model of architectural registers and pc sequencer
    logic [Xlen-1:0]     model [32];
    logic [Xlen-1:0]     pc;
    logic [Xlen-1:0]     pendingPc;
    int                  squashLeft;
    logic [RegAddrW-1:0] expRd [$];
    logic [Xlen-1:0]     expData [$];
    logic [Xlen-1:0]     expTarget [$];

    string curTest = "reset";
    int    issued  = 0;
    int    cycles  = 0;

    pipeCore DUT (
        .clk        (clk),
        .arstN      (arstN),
        .instValid  (instValid),
        .instWord   (instWord),
        .instPc     (instPc),
        .wbValid    (wbValid),
        .wbRd       (wbRd),
        .wbData     (wbData),
        .redirect   (redirect),
        .redirectPc (redirectPc)
    );

    initial clk = 1'b0;
    always #(ClkPeriod / 2) clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkValue(input string what, input logic [Xlen-1:0] expected,
                              input logic [Xlen-1:0] actual);
        if (expected !== actual) begin
            abortRun($sformatf("error in %s, %s: expected 0x%08h, actual 0x%08h",
                               curTest, what, expected, actual));
        end
    endtask

    function automatic logic [2:0] funct3Of(input aluOpT op);
        case (op)
            AluSll:         return F3Sll;
            AluSlt:         return F3Slt;
            AluSltu:        return F3Sltu;
            AluXor:         return F3Xor;
            AluSrl, AluSra: return F3SrlSra;
            AluOr:          return F3Or;
            AluAnd:         return F3And;
            default:        return F3AddSub;
        endcase
    endfunction

    function automatic logic [Xlen-1:0] encR(input aluOpT op, input logic [RegAddrW-1:0] rd,
                                             input logic [RegAddrW-1:0] rs1,
                                             input logic [RegAddrW-1:0] rs2);
        logic [6:0] f7;
        f7 = (op == AluSub || op == AluSra) ? F7Alt : F7Base;
        return {f7, rs2, rs1, funct3Of(op), rd, OpReg};
    endfunction

    // Shift immediates carry funct7 above the shift amount
    function automatic logic [Xlen-1:0] encI(input aluOpT op, input logic [RegAddrW-1:0] rd,
                                             input logic [RegAddrW-1:0] rs1,
                                             input logic [11:0] imm);
        logic [11:0] field;
        field = imm;
        if (op == AluSll || op == AluSrl) field = {F7Base, imm[4:0]};
        if (op == AluSra) field = {F7Alt, imm[4:0]};
        return {field, rs1, funct3Of(op), rd, OpImm};
    endfunction

    function automatic logic [Xlen-1:0] encB(input logic bne, input logic [RegAddrW-1:0] rs1,
                                             input logic [RegAddrW-1:0] rs2,
                                             input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, bne ? F3Bne : F3Beq, off[4:1], off[11], OpBranch};
    endfunction

    // RV32I semantics of the ten operations
    function automatic logic [Xlen-1:0] refAlu(input aluOpT op, input logic [Xlen-1:0] a,
                                               input logic [Xlen-1:0] b);
        case (op)
            AluAdd:  return a + b;
            AluSub:  return a - b;
            AluAnd:  return a & b;
            AluOr:   return a | b;
            AluXor:  return a ^ b;
            AluSll:  return a << b[4:0];
            AluSrl:  return a >> b[4:0];
            AluSra:  return $signed(a) >>> b[4:0];
            AluSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            AluSltu: return (a < b) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    task automatic clearModel();
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        expRd.delete();
        expData.delete();
        expTarget.delete();
        squashLeft = 0;
        pc         = StartPc;
        pendingPc  = StartPc;
    endtask

    // One issue cycle driven on the falling edge
    task automatic slot(input logic valid, input logic [Xlen-1:0] word,
                        output logic live, output logic [Xlen-1:0] slotPc);
        @(negedge clk);
        instValid = valid;
        instWord  = word;
        instPc    = pc;
        slotPc    = pc;
        issued++;
        live = valid && (squashLeft == 0);
        if (squashLeft > 0) begin
            // Wrong path until the branch shadow is over
            squashLeft--;
            pc = (squashLeft == 0) ? pendingPc : pc + 32'd4;
        end else if (valid) begin
            pc = pc + 32'd4;
        end
    endtask

    task automatic idle();
        logic            live;
        logic [Xlen-1:0] p;
        slot(1'b0, '0, live, p);
    endtask

    task automatic retire(input logic [RegAddrW-1:0] rd, input logic [Xlen-1:0] value);
        if (rd != '0) begin
            expRd.push_back(rd);
            expData.push_back(value);
            model[rd] = value;
        end
    endtask

    task automatic issueR(input aluOpT op, input logic [RegAddrW-1:0] rd,
                          input logic [RegAddrW-1:0] rs1, input logic [RegAddrW-1:0] rs2);
        logic            live;
        logic [Xlen-1:0] p;
        slot(1'b1, encR(op, rd, rs1, rs2), live, p);
        if (live) retire(rd, refAlu(op, model[rs1], model[rs2]));
    endtask

    task automatic issueI(input aluOpT op, input logic [RegAddrW-1:0] rd,
                          input logic [RegAddrW-1:0] rs1, input logic [11:0] imm);
        logic            live;
        logic [Xlen-1:0] p;
        slot(1'b1, encI(op, rd, rs1, imm), live, p);
        if (live) retire(rd, refAlu(op, model[rs1], {{20{imm[11]}}, imm}));
    endtask

    task automatic issueBranch(input logic bne, input logic [RegAddrW-1:0] rs1,
                               input logic [RegAddrW-1:0] rs2, input logic [12:0] off);
        logic            live;
        logic            equal;
        logic [Xlen-1:0] p;
        slot(1'b1, encB(bne, rs1, rs2, off), live, p);
        equal = (model[rs1] == model[rs2]);
        if (live && (bne != equal)) begin
            pendingPc  = p + {{19{off[12]}}, off};
            squashLeft = 2;
            expTarget.push_back(pendingPc);
        end
    endtask

    // Builds any 32-bit value from 11-bit pieces
    task automatic loadReg(input logic [RegAddrW-1:0] rd, input logic [Xlen-1:0] value);
        issueI(AluAdd, rd, 5'd0, {1'b0, value[31:21]});
        issueI(AluSll, rd, rd, 12'd11);
        issueI(AluOr, rd, rd, {1'b0, value[20:10]});
        issueI(AluSll, rd, rd, 12'd10);
        issueI(AluOr, rd, rd, {2'b0, value[9:0]});
    endtask

    // Six idle slots empty the pipeline at its fixed latency
    task automatic drain();
        repeat (6) idle();
        if (expRd.size() != 0 || expTarget.size() != 0) begin
            abortRun($sformatf("%s: pipeline drained with %0d writes and %0d redirects missing",
                               curTest, expRd.size(), expTarget.size()));
        end
    endtask

    task automatic applyReset(input int holdCycles);
        @(negedge clk);
        issued++;
        arstN     = 1'b0;
        instValid = 1'b0;
        clearModel();
        repeat (holdCycles) idle();
        arstN = 1'b1;
    endtask

    task automatic testAluOps();
        aluOpT op;
        curTest = "alu ops";
        for (int i = 0; i < 10; i++) begin
            op = aluOpT'(i);
            loadReg(5'd1, $urandom());
            loadReg(5'd2, $urandom());
            repeat (3) idle();
            issueR(op, 5'(3 + i), 5'd1, 5'd2);
            idle();
            if (op != AluSub) issueI(op, 5'(13 + i), 5'd1, 12'($urandom()));
        end
        drain();
    endtask

    task automatic testForwarding();
        curTest = "forwarding";
        loadReg(5'd1, $urandom());
        loadReg(5'd2, $urandom());
        issueR(AluAdd, 5'd3, 5'd1, 5'd2);
        issueR(AluSub, 5'd4, 5'd3, 5'd2);
        issueR(AluXor, 5'd5, 5'd1, 5'd3);
        issueR(AluOr, 5'd6, 5'd4, 5'd4);
        issueR(AluAnd, 5'd7, 5'd5, 5'd6);
        issueR(AluSltu, 5'd8, 5'd7, 5'd7);
        // x9 in both MEM and WB so MEM must win
        issueI(AluAdd, 5'd9, 5'd0, 12'h123);
        issueI(AluXor, 5'd9, 5'd1, 12'h7ff);
        issueR(AluAdd, 5'd10, 5'd9, 5'd9);
        issueI(AluSra, 5'd11, 5'd10, 12'd5);
        issueR(AluSll, 5'd12, 5'd11, 5'd10);
        for (int i = 0; i < 24; i++) begin
            issueR(aluOpT'($urandom_range(0, 9)), 5'($urandom_range(1, 7)),
                   5'($urandom_range(1, 7)), 5'($urandom_range(1, 7)));
        end
        drain();
    endtask

    task automatic testWriteThrough();
        curTest = "write-through and x0";
        issueI(AluAdd, 5'd13, 5'd1, 12'h055);
        issueR(AluAdd, 5'd14, 5'd2, 5'd2);
        issueR(AluXor, 5'd15, 5'd1, 5'd2);
        issueR(AluSub, 5'd16, 5'd13, 5'd1);
        issueI(AluAdd, 5'd0, 5'd1, 12'h3a5);
        issueR(AluOr, 5'd18, 5'd0, 5'd1);
        issueR(AluAdd, 5'd0, 5'd1, 5'd2);
        issueR(AluAdd, 5'd19, 5'd0, 5'd0);
        issueI(AluOr, 5'd20, 5'd0, 12'hfff);
        drain();
    endtask

    task automatic testBranches();
        logic [Xlen-1:0] v;
        curTest = "branches";
        v = $urandom();
        loadReg(5'd23, v ^ 32'h10);
        loadReg(5'd21, v);
        loadReg(5'd22, v);
        issueBranch(1'b0, 5'd21, 5'd22, 13'd16);
        issueI(AluAdd, 5'd24, 5'd0, 12'h111);
        issueI(AluAdd, 5'd25, 5'd0, 12'h222);
        issueR(AluAdd, 5'd24, 5'd21, 5'd23);
        issueR(AluAdd, 5'd26, 5'd21, 5'd0);
        issueBranch(1'b1, 5'd26, 5'd23, 13'h1ff8);
        issueI(AluAdd, 5'd27, 5'd0, 12'h333);
        issueI(AluAdd, 5'd28, 5'd0, 12'h444);
        issueBranch(1'b0, 5'd21, 5'd23, 13'd64);
        issueI(AluAdd, 5'd27, 5'd21, 12'd1);
        issueI(AluAdd, 5'd28, 5'd27, 12'd1);
        issueBranch(1'b1, 5'd21, 5'd22, 13'd64);
        // Taken branch in the shadow of another one never redirects
        issueBranch(1'b0, 5'd22, 5'd21, 13'd32);
        issueBranch(1'b0, 5'd21, 5'd22, 13'd40);
        idle();
        for (int i = 0; i < 8; i++) begin
            issueI(AluAnd, 5'd26, 5'd21, 12'($urandom_range(0, 3)));
            issueI(AluAnd, 5'd27, 5'd22, 12'($urandom_range(0, 3)));
            issueBranch(1'($urandom_range(0, 1)), 5'd26, 5'd27, 13'(4 * $urandom_range(1, 8)));
            issueR(AluAdd, 5'd28, 5'd26, 5'd27);
            issueR(AluSub, 5'd29, 5'd27, 5'd26);
            issueR(AluOr, 5'd30, 5'd28, 5'd29);
        end
        drain();
    endtask

    task automatic testGapsAndReset();
        aluOpT op;
        curTest = "gaps and reset";
        for (int i = 0; i < 40; i++) begin
            if ($urandom_range(0, 2) == 0) idle();
            op = aluOpT'($urandom_range(0, 9));
            if ($urandom_range(0, 1) == 0) begin
                issueR(op, 5'($urandom_range(0, 15)), 5'($urandom_range(0, 15)),
                       5'($urandom_range(0, 15)));
            end else begin
                issueI((op == AluSub) ? AluAdd : op, 5'($urandom_range(0, 15)),
                       5'($urandom_range(0, 15)), 12'($urandom()));
            end
        end
        drain();
        // Writes and a redirect still in flight when reset hits
        issueR(AluAdd, 5'd1, 5'd2, 5'd3);
        issueI(AluOr, 5'd2, 5'd1, 12'h0f0);
        issueBranch(1'b0, 5'd5, 5'd5, 13'd8);
        issueR(AluXor, 5'd3, 5'd1, 5'd2);
        applyReset(4);
        curTest = "after reset";
        for (int r = 1; r < 8; r++) begin
            issueR(AluOr, 5'(r + 8), 5'(r), 5'(r + 1));
        end
        drain();
    endtask

    // Write-back and redirect monitor sampling before the edge updates them
    always @(posedge clk) begin
        if (arstN && wbValid) begin
            if (expRd.size() == 0) begin
                abortRun($sformatf("%s: write-back to x%0d that no instruction should make",
                                   curTest, wbRd));
            end else begin
                checkValue("write-back register", Xlen'(expRd.pop_front()), Xlen'(wbRd));
                checkValue("write-back data", expData.pop_front(), wbData);
            end
        end
        if (arstN && redirect) begin
            if (expTarget.size() == 0) begin
                abortRun($sformatf("%s: redirect to 0x%08h from a branch that is not taken",
                                   curTest, redirectPc));
            end else begin
                checkValue("redirect target", expTarget.pop_front(), redirectPc);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > issued + 64) begin
            abortRun($sformatf("timeout after %0d cycles with %0d issue slots driven",
                               cycles, issued));
        end
    end

    initial begin
        void'($urandom(Seed));
        arstN     = 1'b0;
        instValid = 1'b0;
        instWord  = '0;
        instPc    = '0;
        clearModel();
        repeat (ResetCycles) idle();
        arstN = 1'b1;

        testAluOps();
        testForwarding();
        testWriteThrough();
        testBranches();
        testGapsAndReset();

        if (expRd.size() != 0 || expTarget.size() != 0) begin
            abortRun("expected writes or redirects left over at the end of the run");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule
